// File: Makefile
# Verilator build and run for the ND CPU slice
TOOL   := verilator
FLAGS  := --binary --timing --assert -Wno-fatal
TOP    := tb_nd_cpu
FLIST  := all.f
OBJDIR := obj_dir
BIN    := $(OBJDIR)/V$(TOP)
PASS   := Regression passed
SRCS   := $(shell grep -v '^+' $(FLIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJDIR)

# Pipeline status is the status of grep
run: $(BIN)
	./$(BIN) | tee /dev/stderr | grep -q "$(PASS)"

clean:
	rm -rf $(OBJDIR)

// File: all.f
hdl/nd_pkg.sv
hdl/nd_int_level.sv
hdl/nd_result_stage.sv
hdl/nd_alu_execute.sv
hdl/nd_micro_decode.sv
hdl/nd_apb_port.sv
hdl/nd_cpu_top.sv
sim/tb_nd_cpu.sv

// File: hdl/nd_alu_execute.sv
// ALU execute stage
`timescale 1ns/1ps

module nd_alu_execute import nd_pkg::*; #(
  parameter int DATA_WIDTH = 16
) (
  input  logic                                pclk,
  input  logic                                reset,
  input  logic                                dec_valid,
  input  alu_op_t                             op,
  input  reg_idx_t                            reg_a,
  input  b_src_t                              b_src,
  input  reg_idx_t                            reg_b,
  input  reg_idx_t                            dest,
  input  logic                                wen,
  input  comm_t                               comm,
  input  logic [imm_w-1:0]                    imm,
  input  logic [num_regs-1:0][DATA_WIDTH-1:0] reg_file,
  input  logic [1:0]                          flags,
  input  logic [3:0]                          pil,
  output logic                                ex_valid,
  output logic [DATA_WIDTH-1:0]               ex_result,
  output logic                                ex_carry,
  output reg_idx_t                            ex_dest,
  output logic                                ex_wen,
  output comm_t                               ex_comm,
  output logic [3:0]                          ex_level
);

  logic [DATA_WIDTH-1:0] a_opnd, b_opnd, alu_res;
  logic [DATA_WIDTH:0]   wide;                        // Carry or borrow in top bit
  logic                  alu_carry;
  logic [status_w-1:0]   status_word;

  always_comb begin
    status_word                      = '0;
    status_word[1:0]                 = flags;
    status_word[status_pil_lsb +: 4] = pil;
  end

  // ****************************************
  // Operand select
  // ****************************************
  assign a_opnd = reg_file[reg_a];

  always_comb begin
    case (b_src)
      src_reg: b_opnd = reg_file[reg_b];
      src_imm: b_opnd = DATA_WIDTH'(imm);
      src_pil: b_opnd = DATA_WIDTH'(pil);                 // Current priority level
      default: b_opnd = DATA_WIDTH'(status_word);
    endcase
  end

  always_comb begin
    alu_carry = 1'b0;
    wide      = '0;
    case (op)
      pass_b: alu_res = b_opnd;
      add: begin
        wide      = {1'b0, a_opnd} + {1'b0, b_opnd};
        alu_res   = wide[DATA_WIDTH-1:0];
        alu_carry = wide[DATA_WIDTH];                     // Carry out
      end
      sub: begin
        wide      = {1'b0, a_opnd} - {1'b0, b_opnd};
        alu_res   = wide[DATA_WIDTH-1:0];
        alu_carry = wide[DATA_WIDTH];                     // Borrow when B > A
      end
      and_op: alu_res = a_opnd & b_opnd;
      or_op:  alu_res = a_opnd | b_opnd;
      xor_op: alu_res = a_opnd ^ b_opnd;
      shl: begin
        alu_res   = a_opnd << 1;
        alu_carry = a_opnd[DATA_WIDTH-1];                 // Bit shifted out
      end
      default: begin
        alu_res   = a_opnd >> 1;
        alu_carry = a_opnd[0];
      end
    endcase
  end

  always_ff @(posedge pclk) begin
    if (reset)
      ex_valid <= 1'b0;
    else
      ex_valid <= dec_valid;
  end

  always_ff @(posedge pclk) begin
    if (dec_valid) begin
      ex_result <= alu_res;
      ex_carry  <= alu_carry;
      ex_dest   <= dest;
      ex_wen    <= wen;
      ex_comm   <= comm;
      ex_level  <= imm[3:0];                              // PIR bit for COMM
    end
  end

  // Two-cycle APB transfers keep launches apart
  a_ex_spaced: assert property (@(posedge pclk) disable iff (reset) ex_valid |=> !ex_valid);

endmodule

// File: hdl/nd_apb_port.sv
// APB host port
`timescale 1ns/1ps

module nd_apb_port import nd_pkg::*; #(
  parameter int DATA_WIDTH = 16
) (
  input  logic                                pclk,
  input  logic                                reset,
  input  logic                                psel,
  input  logic                                penable,
  input  logic                                pwrite,
  input  logic [7:0]                          paddr,
  input  logic [31:0]                         pwdata,
  output logic [31:0]                         prdata,
  output logic                                pready,
  output logic                                pslverr,
  input  logic                                busy,       // Pipeline not empty
  input  logic [num_regs-1:0][DATA_WIDTH-1:0] reg_file,
  input  logic [1:0]                          flags,
  input  logic [15:0]                         pir,
  input  logic [3:0]                          pil,
  output logic                                launch,     // One cycle per accepted microword
  output logic [31:0]                         microword
);

  apb_state_t           state;
  logic                 in_access;
  logic                 hit_reg, hit_status, hit_pir;
  logic                 rd_ok, wr_ok, addr_err;
  logic [7:0]           reg_off;
  reg_idx_t             reg_sel;
  logic [status_w-1:0]  status_word;

  // ****************************************
  // Address decode
  // ****************************************
  assign reg_off    = paddr - addr_reg_base;
  assign reg_sel    = reg_idx_t'(reg_off >> 2);
  assign hit_reg    = (paddr[1:0] == 2'b00) && (paddr >= addr_reg_base) &&
                      (reg_off <= 8'(4 * (num_regs - 1)));
  assign hit_status = (paddr == addr_status);
  assign hit_pir    = (paddr == addr_pir);
  assign rd_ok      = hit_reg | hit_status | hit_pir;   // Microword slot is write only
  assign wr_ok      = (paddr == addr_microword) && ((pwdata & rsvd_mask) == '0);
  assign addr_err   = pwrite ? !wr_ok : !rd_ok;

  // Errors and writes finish at once, good reads wait for an empty pipeline
  assign in_access = (state != st_idle) && psel && penable;
  assign pready    = in_access && (pwrite || addr_err || !busy);
  assign pslverr   = pready && addr_err;
  assign launch    = pready && pwrite && wr_ok;
  assign microword = pwdata;

  always_comb begin
    status_word                                = '0;
    status_word[1:0]                           = flags;
    status_word[status_pil_lsb +: 4]           = pil;
  end

  always_comb begin
    prdata = '0;
    if (pready && !pwrite && rd_ok) begin               // Drive only on a good read
      if (hit_reg)
        prdata = 32'(reg_file[reg_sel]);
      else if (hit_status)
        prdata = 32'(status_word);
      else
        prdata = 32'(pir);
    end
  end

  // ****************************************
  // Transfer FSM
  // ****************************************
  always_ff @(posedge pclk) begin
    if (reset) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle:      if (psel && !penable) state <= st_access;   // Setup phase seen
        st_access:    state <= pready ? st_idle : st_wait_read;
        st_wait_read: if (pready) state <= st_idle;               // Pipeline drained
        default:      state <= st_idle;
      endcase
    end
  end

  a_penable_psel: assert property (@(posedge pclk) disable iff (reset) penable |-> psel);

endmodule

// File: hdl/nd_cpu_top.sv
// ND microcoded CPU slice top
`timescale 1ns/1ps

module nd_cpu_top import nd_pkg::*; #(
  parameter int DATA_WIDTH = 16                      // ALU and register width
) (
  input  logic        pclk,
  input  logic        reset,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [7:0]  paddr,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr,
  input  logic [4:0]  bint_n,                        // BINT10..13, BINT15, active low
  output logic [3:0]  pil
);

  // ****************************************
  // Pipeline wiring
  // ****************************************
  logic                                  launch;
  logic [31:0]                           microword;
  logic                                  busy;
  logic                                  dec_valid;
  alu_op_t                               op;
  reg_idx_t                              reg_a;
  b_src_t                                b_src;
  reg_idx_t                              reg_b;
  reg_idx_t                              dest;
  logic                                  wen;
  comm_t                                 comm;
  logic [imm_w-1:0]                      imm;
  logic                                  ex_valid;
  logic [DATA_WIDTH-1:0]                 ex_result;
  logic                                  ex_carry;
  reg_idx_t                              ex_dest;
  logic                                  ex_wen;
  comm_t                                 ex_comm;
  logic [3:0]                            ex_level;
  logic [num_regs-1:0][DATA_WIDTH-1:0]   reg_file;
  logic [1:0]                            flags;
  logic [15:0]                           pir;

  assign busy = dec_valid | ex_valid;                // Any stage holding a microword

  nd_apb_port #(.DATA_WIDTH(DATA_WIDTH)) u_apb (
    .pclk, .reset, .psel, .penable, .pwrite, .paddr, .pwdata,
    .prdata, .pready, .pslverr,
    .busy, .reg_file, .flags, .pir, .pil,
    .launch, .microword
  );

  nd_micro_decode u_dec (
    .pclk, .reset, .launch, .microword,
    .dec_valid, .op, .reg_a, .b_src, .reg_b, .dest, .wen, .comm, .imm
  );

  nd_alu_execute #(.DATA_WIDTH(DATA_WIDTH)) u_exe (
    .pclk, .reset, .dec_valid, .op, .reg_a, .b_src, .reg_b, .dest, .wen, .comm, .imm,
    .reg_file, .flags, .pil,
    .ex_valid, .ex_result, .ex_carry, .ex_dest, .ex_wen, .ex_comm, .ex_level
  );

  nd_result_stage #(.DATA_WIDTH(DATA_WIDTH)) u_res (
    .pclk, .reset, .ex_valid, .ex_result, .ex_carry, .ex_dest, .ex_wen,
    .reg_file, .flags
  );

  nd_int_level u_int (
    .pclk, .reset, .ex_valid, .ex_comm, .ex_level, .bint_n,
    .pir, .pil
  );

endmodule

// File: hdl/nd_int_level.sv
// Priority interrupt level logic
`timescale 1ns/1ps

module nd_int_level import nd_pkg::*; (
  input  logic               pclk,
  input  logic               reset,
  input  logic               ex_valid,
  input  comm_t              ex_comm,
  input  logic [3:0]         ex_level,
  input  logic [num_ext-1:0] bint_n,                     // Active low lines
  output logic [15:0]        pir,
  output logic [3:0]         pil
);

  logic [15:0] ext_req;
  logic [15:0] pending;
  logic [3:0]  top_lvl;

  // Software request register driven by COMM
  always_ff @(posedge pclk) begin
    if (reset) begin
      pir <= '0;
    end else if (ex_valid) begin
      case (ex_comm)
        comm_set_pir: pir[ex_level] <= 1'b1;
        comm_clr_pir: pir[ex_level] <= 1'b0;
        comm_clr_all: pir <= '0;
        default:      pir <= pir;
      endcase
    end
  end

  // ****************************************
  // Merge and priority encode
  // ****************************************
  always_comb begin
    ext_req = '0;
    for (int i = 0; i < num_ext; i++)
      ext_req[ext_levels[i]] = ~bint_n[i];               // Line low means request
  end

  assign pending = pir | ext_req;

  always_comb begin
    top_lvl = '0;
    for (int i = 1; i < 16; i++)
      if (pending[i]) top_lvl = 4'(i);                   // Highest wins
  end

  always_ff @(posedge pclk) begin
    if (reset)
      pil <= '0;
    else
      pil <= top_lvl;
  end

endmodule

// File: hdl/nd_micro_decode.sv
// Microword decode stage
`timescale 1ns/1ps

module nd_micro_decode import nd_pkg::*; (
  input  logic             pclk,
  input  logic             reset,
  input  logic             launch,
  input  logic [31:0]      microword,
  output logic             dec_valid,
  output alu_op_t          op,
  output reg_idx_t         reg_a,
  output b_src_t           b_src,
  output reg_idx_t         reg_b,
  output reg_idx_t         dest,
  output logic             wen,
  output comm_t            comm,
  output logic [imm_w-1:0] imm
);

  // Valid tracks the launch strobe
  always_ff @(posedge pclk) begin
    if (reset)
      dec_valid <= 1'b0;
    else
      dec_valid <= launch;
  end

  // ****************************************
  // Field split, loaded on launch only
  // ****************************************
  always_ff @(posedge pclk) begin
    if (launch) begin
      op    <= alu_op_t'(microword[op_lsb +: 3]);       // ALU function
      reg_a <= reg_idx_t'(microword[reg_a_lsb +: 2]);   // A register
      b_src <= b_src_t'(microword[b_src_lsb +: 2]);     // B operand select
      reg_b <= reg_idx_t'(microword[reg_b_lsb +: 2]);
      dest  <= reg_idx_t'(microword[dest_lsb +: 2]);    // Writeback target
      wen   <= microword[wen_bit];
      comm  <= comm_t'(microword[comm_lsb +: 2]);       // PIR command
      imm   <= microword[imm_lsb +: imm_w];
    end
  end

  a_op_legal: assert property (@(posedge pclk) disable iff (reset)
    dec_valid |-> !$isunknown({op, b_src, comm}) &&
                  (op inside {pass_b, add, sub, and_op, or_op, xor_op, shl, shr}));

endmodule

// File: hdl/nd_pkg.sv
// ND slice shared definitions
package nd_pkg;

  // ****************************************
  // Microword control fields
  // ****************************************
  typedef enum logic [2:0] {
    pass_b, add, sub, and_op, or_op, xor_op, shl, shr
  } alu_op_t;                                        // ALU field

  typedef enum logic [1:0] {
    src_reg, src_imm, src_pil, src_status
  } b_src_t;                                         // B operand source, like IDB source

  typedef enum logic [1:0] {
    comm_none, comm_set_pir, comm_clr_pir, comm_clr_all
  } comm_t;                                          // COMM field

  typedef enum logic [1:0] {
    st_idle, st_access, st_wait_read
  } apb_state_t;

  localparam int op_lsb    = 28;                     // Bits 30..28
  localparam int reg_a_lsb = 26;                     // Bits 27..26
  localparam int b_src_lsb = 24;                     // Bits 25..24
  localparam int reg_b_lsb = 22;                     // Bits 23..22
  localparam int dest_lsb  = 20;                     // Bits 21..20
  localparam int wen_bit   = 19;
  localparam int comm_lsb  = 17;                     // Bits 18..17
  localparam int imm_lsb   = 0;                      // Bits 15..0
  localparam int imm_w     = 16;
  localparam logic [31:0] rsvd_mask = 32'h8001_0000; // Bits 31 and 16 must be zero

  // ****************************************
  // APB address map and status layout
  // ****************************************
  localparam logic [7:0] addr_microword = 8'h00;     // Write only
  localparam logic [7:0] addr_reg_base  = 8'h04;     // R0..R3 at 04..10
  localparam logic [7:0] addr_status    = 8'h14;
  localparam logic [7:0] addr_pir       = 8'h18;

  localparam int num_regs       = 4;
  typedef logic [1:0] reg_idx_t;
  localparam int zero_flag      = 0;                 // Flag bit positions
  localparam int carry_flag     = 1;
  localparam int status_w       = 8;                 // Flags low, PIL in 7..4
  localparam int status_pil_lsb = 4;

  // External interrupt lines, index 0 is BINT10
  localparam int num_ext = 5;
  localparam logic [num_ext-1:0][3:0] ext_levels = {4'd15, 4'd13, 4'd12, 4'd11, 4'd10};

endpackage

// File: hdl/nd_result_stage.sv
// Register file writeback stage
`timescale 1ns/1ps

module nd_result_stage import nd_pkg::*; #(
  parameter int DATA_WIDTH = 16
) (
  input  logic                                pclk,
  input  logic                                reset,
  input  logic                                ex_valid,
  input  logic [DATA_WIDTH-1:0]               ex_result,
  input  logic                                ex_carry,
  input  reg_idx_t                            ex_dest,
  input  logic                                ex_wen,
  output logic [num_regs-1:0][DATA_WIDTH-1:0] reg_file,
  output logic [1:0]                          flags
);

  logic res_zero;

  assign res_zero = (ex_result == '0);

  // ****************************************
  // Register file, R0..R3
  // ****************************************
  always_ff @(posedge pclk) begin
    if (reset) begin
      reg_file <= '0;
    end else if (ex_valid && ex_wen) begin
      reg_file[ex_dest] <= ex_result;                    // Write only when enabled
    end
  end

  // Flags follow every executed microword, written or not
  always_ff @(posedge pclk) begin
    if (reset) begin
      flags <= '0;
    end else if (ex_valid) begin
      flags[zero_flag]  <= res_zero;
      flags[carry_flag] <= ex_carry;                     // Carry, borrow or shift out
    end
  end

endmodule

// File: sim/tb_nd_cpu.sv
// ND CPU slice testbench
`timescale 1ns/1ps

module tb_nd_cpu import nd_pkg::*; ();

  localparam int DATA_WIDTH = 16;
  localparam int wait_limit = 20;                      // Cycles before a transfer counts as hung

  logic        pclk, reset;
  logic        psel, penable, pwrite;
  logic [7:0]  paddr;
  logic [31:0] pwdata, prdata;
  logic        pready, pslverr;
  logic [4:0]  bint_n;                                 // BINT10..13, BINT15
  logic [3:0]  pil;
  logic [15:0] m_regs [num_regs];                      // Reference registers
  logic        m_zero, m_carry;
  logic [15:0] m_pir;
  logic [31:0] exp_rdata;
  logic        exp_err;
  logic        hung;
  int          wait_cycles, mismatches, failures;
  int          pipe_left;                              // Stages still holding a microword
  logic [31:0] word;

  nd_cpu_top #(.DATA_WIDTH(DATA_WIDTH)) UUT (.*);

  initial begin
    pclk = 1'b0;
    forever #4 pclk = ~pclk;                           // 8 ns period
  end

  // ****************************************
  // Reference model
  // ****************************************
  function automatic logic [3:0] pending_level();
    logic [15:0] pend;
    logic [3:0]  lvl;
    pend = m_pir;
    lvl  = 4'd0;
    for (int i = 0; i < num_ext; i++)
      if (!bint_n[i]) pend[ext_levels[i]] = 1'b1;      // Low line is a request
    for (int i = 1; i < 16; i++)
      if (pend[i]) lvl = 4'(i);                        // Highest level wins
    return lvl;
  endfunction

  function automatic logic [15:0] status_value();
    return {8'h00, pending_level(), 2'b00, m_carry, m_zero};
  endfunction

  function automatic logic [31:0] encode_word(alu_op_t op, int ra, b_src_t bs, int rb, int dst,
                                              logic wen, comm_t cm, logic [15:0] imm);
    return {1'b0, op, 2'(ra), bs, 2'(rb), 2'(dst), wen, cm, 1'b0, imm};
  endfunction

  task automatic exec_reference(input logic [31:0] w);
    logic [15:0] a, b, r;
    logic [16:0] wide;
    logic        c;
    a = m_regs[w[27:26]];
    case (b_src_t'(w[25:24]))
      src_reg: b = m_regs[w[23:22]];
      src_imm: b = w[15:0];
      src_pil: b = 16'(pending_level());               // PIR not yet written back
      default: b = status_value();
    endcase
    c = 1'b0;
    case (alu_op_t'(w[30:28]))
      pass_b: r = b;
      add: begin
        wide = {1'b0, a} + {1'b0, b};
        r    = wide[15:0];
        c    = wide[16];
      end
      sub: begin
        r = a - b;
        c = (b > a);                                   // Borrow when B exceeds A
      end
      and_op: r = a & b;
      or_op:  r = a | b;
      xor_op: r = a ^ b;
      shl: begin
        r = a << 1;
        c = a[15];
      end
      default: begin
        r = a >> 1;
        c = a[0];
      end
    endcase
    m_zero  = (r == 16'h0000);
    m_carry = c;
    if (w[19]) m_regs[w[21:20]] = r;
    case (comm_t'(w[18:17]))
      comm_set_pir: m_pir[w[3:0]] = 1'b1;
      comm_clr_pir: m_pir[w[3:0]] = 1'b0;
      comm_clr_all: m_pir = 16'h0000;
      default: ;
    endcase
  endtask

  // ****************************************
  // APB driving
  // ****************************************
  task automatic bus_transfer(input logic wr, input logic [7:0] addr, input logic [31:0] data,
                              input logic [31:0] exp_data, input logic err);
    @(negedge pclk);
    psel      = 1'b1;                                  // Setup phase
    penable   = 1'b0;
    pwrite    = wr;
    paddr     = addr;
    pwdata    = data;
    exp_rdata = exp_data;
    exp_err   = err;
    @(negedge pclk);
    penable     = 1'b1;
    wait_cycles = 0;
    #1;
    while (!pready && wait_cycles < wait_limit) begin   // Read held while busy
      @(negedge pclk);
      #1;
      wait_cycles++;
    end
    if (!pready)
      hung = 1'b1;
    else
      @(posedge pclk);                                 // Transfer completes here
  endtask

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
    bus_transfer(1'b1, addr, data, 32'h0, 1'b0);
  endtask

  task automatic apb_read(input logic [7:0] addr, input logic [15:0] exp);
    bus_transfer(1'b0, addr, 32'h0, {16'h0000, exp}, 1'b0);
  endtask

  task automatic expect_error(input logic wr, input logic [7:0] addr, input logic [31:0] data);
    bus_transfer(wr, addr, data, 32'h0, 1'b1);
  endtask

  task automatic launch_word(input logic [31:0] w);
    apb_write(addr_microword, w);
    exec_reference(w);
  endtask

  task automatic check_state();
    for (int i = 0; i < num_regs; i++)
      apb_read(addr_reg_base + 8'(4 * i), m_regs[i]);
    apb_read(addr_pir, m_pir);
    apb_read(addr_status, status_value());             // Last, so PIL has settled
  endtask

  task automatic drive_bint(input logic [4:0] lines);
    @(negedge pclk);
    psel    = 1'b0;                                    // Bus idle meanwhile
    penable = 1'b0;
    bint_n  = lines;
  endtask

  task automatic check_pil_port(input logic [3:0] exp);
    @(negedge pclk);
    assert (pil == exp) else begin
      mismatches++;
      $display("Mismatch pil: got %h expected %h", pil, exp);
    end
  endtask

  // ****************************************
  // Checkers
  // ****************************************
  // Accepted microword sits in decode, then in execute
  always @(posedge pclk) begin
    if (reset)
      pipe_left <= 0;
    else if (psel && penable && pready && pwrite && !exp_err && paddr == addr_microword)
      pipe_left <= 2;
    else if (pipe_left != 0)
      pipe_left <= pipe_left - 1;
  end

  a_rdata: assert property (@(posedge pclk) disable iff (reset)
    (psel && penable && pready && !pwrite && !pslverr) |-> (prdata == exp_rdata))
    else begin
      mismatches++;
      $display("Mismatch prdata: got %h expected %h at paddr %h", $sampled(prdata),
               exp_rdata, paddr);
    end

  a_slverr: assert property (@(posedge pclk) disable iff (reset)
    (psel && penable && pready) |-> (pslverr == exp_err))
    else begin
      mismatches++;
      $display("Mismatch pslverr: got %h expected %h", $sampled(pslverr), exp_err);
    end

  a_stall: assert property (@(posedge pclk) disable iff (reset)
    (psel && penable && !pwrite && !exp_err && pipe_left != 0) |-> !pready)
    else begin
      failures++;
      $display("Read completed while the pipeline still held a microword");
    end

  always @(negedge pclk) begin
    if (hung) begin
      failures++;
      $display("Timeout: pready low for %0d cycles at paddr %h", wait_limit, paddr);
      $display("Closing count: %0d mismatches, %0d other errors", mismatches, failures);
      $display("Regression failed");
      $finish;
    end
  end

  // ****************************************
  // Stimulus
  // ****************************************
  initial begin
    void'($urandom(32'h9e64));
    reset       = 1'b1;
    psel        = 1'b0;
    penable     = 1'b0;
    pwrite      = 1'b0;
    paddr       = 8'h00;
    pwdata      = 32'h0;
    bint_n      = 5'b11111;                            // All lines released
    hung        = 1'b0;
    exp_rdata   = 32'h0;
    exp_err     = 1'b0;
    wait_cycles = 0;
    mismatches  = 0;
    failures    = 0;
    word        = 32'h0;
    for (int i = 0; i < num_regs; i++)
      m_regs[i] = 16'h0000;
    m_zero  = 1'b0;
    m_carry = 1'b0;
    m_pir   = 16'h0000;
    repeat (8) @(posedge pclk);
    @(negedge pclk);
    reset = 1'b0;

    // Add with immediate
    launch_word(encode_word(pass_b, 0, src_imm, 0, 0, 1'b1, comm_none, 16'h7000));
    launch_word(encode_word(add, 0, src_imm, 0, 1, 1'b1, comm_none, 16'h0234));
    apb_read(addr_reg_base + 8'd4, m_regs[1]);

    // Zero result, then borrow
    launch_word(encode_word(sub, 1, src_reg, 1, 2, 1'b1, comm_none, 16'h0000));
    apb_read(addr_status, status_value());
    launch_word(encode_word(sub, 0, src_imm, 0, 3, 1'b1, comm_none, 16'hffff));
    apb_read(addr_status, status_value());

    for (int n = 0; n < 40; n++) begin
      word = $urandom & ~rsvd_mask;                    // Reserved bits kept clear
      launch_word(word);
      check_state();
    end

    // PIR level 14 against BINT12
    launch_word(encode_word(pass_b, 0, src_imm, 0, 0, 1'b0, comm_clr_all, 16'h0000));
    launch_word(encode_word(pass_b, 0, src_imm, 0, 0, 1'b0, comm_set_pir, 16'd14));
    drive_bint(5'b11011);
    apb_read(addr_pir, m_pir);
    apb_read(addr_status, status_value());
    check_pil_port(4'd14);
    launch_word(encode_word(pass_b, 0, src_imm, 0, 0, 1'b0, comm_clr_pir, 16'd14));
    apb_read(addr_pir, m_pir);
    apb_read(addr_status, status_value());
    check_pil_port(4'd12);
    drive_bint(5'b11111);
    apb_read(addr_status, status_value());
    check_pil_port(4'd0);

    // Slave errors leave state alone
    expect_error(1'b0, 8'h40, 32'h0);
    expect_error(1'b1, addr_status, 32'h0000_0001);
    expect_error(1'b1, addr_microword, 32'h8000_0000 |
                 encode_word(pass_b, 0, src_imm, 0, 1, 1'b1, comm_set_pir, 16'h00ff));
    check_state();

    // Read straight after a launch
    launch_word(encode_word(add, 2, src_imm, 0, 2, 1'b1, comm_none, 16'h0101));
    apb_read(addr_reg_base + 8'd8, m_regs[2]);
    assert (wait_cycles > 0) else begin
      failures++;
      $display("Read right after a launch was not held off");
    end

    drive_bint(5'b11111);
    $display("Closing count: %0d mismatches, %0d other errors", mismatches, failures);
    if (mismatches == 0 && failures == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

endmodule
